// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module armTb -f tb.f -o Vsim

run: compile
	./obj_dir/Vsim | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/armMonitor.sv ====
`timescale 1ns/1ps
`include "arm_consts.svh"

module armMonitor (
  input  logic               clk,
  input  logic               rstN,
  input  logic               memWrite,
  input  logic [`WORD_W-1:0] dataAddr,
  input  logic [`WORD_W-1:0] writeData,
  output logic               allSeen,
  output int                 testsPassed,
  output int                 testsFailed,
  output int                 errorCount
);

  localparam string PatternFile = "bench/arm_patterns.txt";

  logic [`WORD_W-1:0] expected [0:255];
  int                 storeCount = 0;
  int                 expIdx = 0;
  int                 testErrors = 0;

  initial begin
    testsPassed = 0;
    testsFailed = 0;
    errorCount  = 0;
    $readmemh(PatternFile, expected);
    storeCount = expected[8'h7F];
  end

  assign allSeen = (expIdx >= storeCount) && (storeCount > 0);

  // Records are test, address, value starting at word 0x80
  task automatic checkStore();
    int                 base;
    logic [`WORD_W-1:0] expTest;
    logic [`WORD_W-1:0] expAddr;
    logic [`WORD_W-1:0] expData;
    base    = 8'h80 + 3 * expIdx;
    expTest = expected[base];
    expAddr = expected[base + 1];
    expData = expected[base + 2];
    if (dataAddr !== expAddr) begin
      $display("MISMATCH at %0t: dataAddr expected %h actual %h", $time, expAddr, dataAddr);
      testErrors++;
    end
    if (writeData !== expData) begin
      $display("MISMATCH at %0t: writeData expected %h actual %h", $time, expData, writeData);
      testErrors++;
    end
    // Last store of this test
    if (expIdx + 1 == storeCount || expected[base + 3] != expTest) begin
      if (testErrors == 0) begin
        $display("Test %0d: PASS", expTest);
        testsPassed++;
      end else begin
        $display("Test %0d: FAIL with %0d errors", expTest, testErrors);
        testsFailed++;
      end
      testErrors = 0;
    end
    expIdx++;
  endtask

  // Sampled mid-cycle, the store commits at the next rising edge
  always @(negedge clk) begin
    if (memWrite) begin
      if (!rstN) begin
        $display("ERROR at %0t: store to %h while reset is asserted", $time, dataAddr);
        errorCount++;
      end else if (expIdx >= storeCount) begin
        $display("ERROR at %0t: store of %h to %h after all expected stores were seen",
                 $time, writeData, dataAddr);
        errorCount++;
      end else begin
        checkStore();
      end
    end
  end

endmodule

// ==== bench/armTb.sv ====
`timescale 1ns/1ps
`include "arm_consts.svh"

module armTb;

  localparam string PatternFile = "bench/arm_patterns.txt";
  localparam logic [`WORD_W-1:0] NopWord = 32'hF000_0000;

  logic               clk;
  logic               rstN;
  logic [`WORD_W-1:0] pc;
  logic [`WORD_W-1:0] instruction = NopWord;
  logic [`WORD_W-1:0] dataAddr;
  logic [`WORD_W-1:0] writeData;
  logic               memWrite;
  logic [`WORD_W-1:0] readData = '0;

  logic [`WORD_W-1:0] patterns [0:255];
  logic [`WORD_W-1:0] rom [0:63];
  logic [`WORD_W-1:0] ram [0:127];
  int                 progLen;
  int                 cycleLimit;
  int                 cycles;
  logic               timedOut;

  logic               allSeen;
  int                 testsPassed;
  int                 testsFailed;
  int                 errorCount;

  arm u_arm (
    .clk         (clk),
    .rstN        (rstN),
    .pc          (pc),
    .instruction (instruction),
    .dataAddr    (dataAddr),
    .writeData   (writeData),
    .memWrite    (memWrite),
    .readData    (readData)
  );

  armMonitor monitor (
    .clk         (clk),
    .rstN        (rstN),
    .memWrite    (memWrite),
    .dataAddr    (dataAddr),
    .writeData   (writeData),
    .allSeen     (allSeen),
    .testsPassed (testsPassed),
    .testsFailed (testsFailed),
    .errorCount  (errorCount)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [`WORD_W-1:0] fetchWord(input logic [`WORD_W-1:0] addr);
    logic [`WORD_W-1:0] word;
    if (addr[`WORD_W-1:2] < progLen) begin
      word = rom[addr[7:2]];
    end else begin
      word = NopWord;
    end
    return word;
  endfunction

  // Both memories answer in the cycle, inputs settle 1 ns after the edge
  always @(posedge clk) begin
    #1;
    instruction = fetchWord(pc);
    readData    = ram[dataAddr[8:2]];
  end

  always @(posedge clk) begin
    if (memWrite) begin
      ram[dataAddr[8:2]] <= writeData;
    end
  end

  initial begin
    rstN     = 1'b0;
    timedOut = 1'b0;
    cycles   = 0;
    $readmemh(PatternFile, patterns);
    for (int i = 0; i < 64; i++) begin
      rom[i] = patterns[i];
    end
    // Fill spans the whole byte address
    for (int i = 0; i < 128; i++) begin
      ram[i] = 32'hA500_0000 | (i << 2);
    end
    for (int i = 0; i < 16; i++) begin
      ram[i] = patterns[8'h40 + i];
    end
    progLen    = patterns[8'h7E];
    cycleLimit = 4 * progLen + 40;

    repeat (8) @(posedge clk);
    #1 rstN = 1'b1;

    while (!allSeen && !timedOut) begin
      @(posedge clk);
      cycles++;
      if (cycles >= cycleLimit) begin
        timedOut = 1'b1;
      end
    end
    // Room for a stray store after the last expected one
    repeat (10) @(posedge clk);

    if (timedOut) begin
      $display("ERROR: timeout after %0d cycles with expected stores still outstanding", cycles);
    end
    $display("Summary: %0d tests passed, %0d tests failed, %0d other errors, %0d assertion failures",
             testsPassed, testsFailed, errorCount, u_arm.checkerInst.assertFails);
    if (!timedOut && testsFailed == 0 && errorCount == 0 &&
        u_arm.checkerInst.assertFails == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== bench/arm_checker.sv ====
`timescale 1ns/1ps
`include "arm_consts.svh"

module armChecker (
  input logic               clk,
  input logic               rstN,
  input logic [`WORD_W-1:0] pc,
  input logic               memWrite
);

  int assertFails = 0;

  noStoreInReset: assert property (@(posedge clk) !rstN |-> !memWrite)
    else begin
      assertFails++;
      $error("memWrite high during reset");
    end

  pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
    else begin
      assertFails++;
      $error("pc not word aligned");
    end

  // First fetch after reset is at address 0
  pcStartsAtZero: assert property (@(posedge clk) $rose(rstN) |-> pc == '0)
    else begin
      assertFails++;
      $error("pc not zero after reset");
    end

endmodule

bind arm armChecker checkerInst (
  .clk      (clk),
  .rstN     (rstN),
  .pc       (pc),
  .memWrite (memWrite)
);

// ==== bench/arm_patterns.txt ====
// Words 0x00-0x3F: program, one instruction word per column
// Words 0x40-0x4F: initial RAM words 0-15; 0x7E program length; 0x7F store count
// Words from 0x80: expected stores, columns are test number, byte address, value
@00
E58FF100 E20F0000 E28F1000 F0000000 F0000000 E280205A E2803033 E5904008
E5801110 E2826010 E0827003 E0428003 E0029003 E182A003 E243B040 E202C00F
E383D080 E5806120 E5807124 E5808128 E580912C E580A130 E580B134 E580C138
E580D13C E5804140 E252E05A 05802144 15803148 E253E05A B580314C A5802150
15801154 E252E05A 1A000002 E5806158 0A000002 E580715C E5808160 E5809164
E580A168 EAFFFFFE
@40
11111111 22222222 CAFE1234 44444444 55555555 66666666 77777777 88888888
99999999 AAAAAAAA BBBBBBBB CCCCCCCC DDDDDDDD EEEEEEEE 0F0F0F0F F0F0F0F0
@7E
0000002A 00000010
@80
00000001 00000108 00000008
00000002 00000110 00000010
00000003 00000120 0000006A
00000003 00000124 0000008D
00000003 00000128 00000027
00000003 0000012C 00000012
00000003 00000130 0000007B
00000003 00000134 FFFFFFF3
00000003 00000138 0000000A
00000003 0000013C 000000B3
00000004 00000140 CAFE1234
00000005 00000144 0000005A
00000005 0000014C 00000033
00000005 00000154 00000010
00000006 00000158 0000006A
00000006 00000168 0000007B

// ==== design/arm.sv ====
`timescale 1ns/1ps
`include "arm_consts.svh"

module arm (
  input  logic               clk,
  input  logic               rstN,
  output logic [`WORD_W-1:0] pc,
  input  logic [`WORD_W-1:0] instruction,
  output logic [`WORD_W-1:0] dataAddr,
  output logic [`WORD_W-1:0] writeData,
  output logic               memWrite,
  input  logic [`WORD_W-1:0] readData
);
  import armPkg::*;

  fetchDecodeT        fetchDecode;
  decodeExecT         decodeExec;
  execMemT            execMem;
  regWriteT           writeBack;
  logic               branchTaken;
  logic [`WORD_W-1:0] branchTarget;

  fetch stageFetch (
    .clk          (clk),
    .rstN         (rstN),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget),
    .pc           (pc),
    .instruction  (instruction),
    .fetchOut     (fetchDecode)
  );

  // Taken branch kills the instruction in decode
  decode stageDecode (
    .clk       (clk),
    .rstN      (rstN),
    .flush     (branchTaken),
    .fetchIn   (fetchDecode),
    .writeBack (writeBack),
    .decodeOut (decodeExec)
  );

  execute stageExecute (
    .clk          (clk),
    .rstN         (rstN),
    .execIn       (decodeExec),
    .branchTaken  (branchTaken),
    .branchTarget (branchTarget),
    .execOut      (execMem)
  );

  memWriteback stageMemWb (
    .clk       (clk),
    .rstN      (rstN),
    .memIn     (execMem),
    .dataAddr  (dataAddr),
    .writeData (writeData),
    .memWrite  (memWrite),
    .readData  (readData),
    .writeBack (writeBack)
  );

endmodule

// ==== design/armPkg.sv ====
`include "arm_consts.svh"

package armPkg;

  typedef enum logic [1:0] {
    aluAdd = 2'b00,
    aluSub = 2'b01,
    aluAnd = 2'b10,
    aluOrr = 2'b11
  } aluOpT;

  // Fetch to decode
  typedef struct packed {
    logic [`WORD_W-1:0] instr;
    logic [`WORD_W-1:0] pcPlus8;
  } fetchDecodeT;

  // Decode to execute, all control bits low is a bubble
  typedef struct packed {
    logic [3:0]         cond;
    aluOpT              aluOp;
    logic               setFlags;
    logic               useImm;
    logic               regWrite;
    logic               memWrite;
    logic               memToReg;
    logic               branch;
    logic [3:0]         dest;
    logic [`WORD_W-1:0] opA;
    logic [`WORD_W-1:0] opB;
    logic [`WORD_W-1:0] imm;
    logic [`WORD_W-1:0] storeData;
  } decodeExecT;

  // Execute to memory
  typedef struct packed {
    logic               regWrite;
    logic               memWrite;
    logic               memToReg;
    logic [3:0]         dest;
    logic [`WORD_W-1:0] aluResult;
    logic [`WORD_W-1:0] storeData;
  } execMemT;

  // Memory to writeback
  typedef struct packed {
    logic               regWrite;
    logic               memToReg;
    logic [3:0]         dest;
    logic [`WORD_W-1:0] aluResult;
    logic [`WORD_W-1:0] readData;
  } memWbT;

  // Register file write port
  typedef struct packed {
    logic               en;
    logic [3:0]         dest;
    logic [`WORD_W-1:0] value;
  } regWriteT;

endpackage

// ==== design/arm_consts.svh ====
`ifndef ARM_CONSTS_SVH
`define ARM_CONSTS_SVH

`define WORD_W 32
`define NUM_REGS 15

// Data processing opcodes, bits 24:21
`define OP_AND 4'b0000
`define OP_SUB 4'b0010
`define OP_ADD 4'b0100
`define OP_ORR 4'b1100

// Condition field, bits 31:28
`define COND_EQ 4'b0000
`define COND_NE 4'b0001
`define COND_CS 4'b0010
`define COND_CC 4'b0011
`define COND_MI 4'b0100
`define COND_PL 4'b0101
`define COND_VS 4'b0110
`define COND_VC 4'b0111
`define COND_HI 4'b1000
`define COND_LS 4'b1001
`define COND_GE 4'b1010
`define COND_LT 4'b1011
`define COND_GT 4'b1100
`define COND_LE 4'b1101
`define COND_AL 4'b1110

`endif

// ==== design/decode.sv ====
`timescale 1ns/1ps
`include "arm_consts.svh"

module decode (
  input  logic                clk,
  input  logic                rstN,
  input  logic                flush,
  input  armPkg::fetchDecodeT fetchIn,
  input  armPkg::regWriteT    writeBack,
  output armPkg::decodeExecT  decodeOut
);
  import armPkg::*;

  logic [`WORD_W-1:0] regFile [`NUM_REGS];
  logic [`WORD_W-1:0] instr;
  decodeExecT         decodeNext;

  assign instr = fetchIn.instr;

  // R15 gives PC+8 and a write in this cycle is seen by the read
  function automatic logic [`WORD_W-1:0] readReg(input logic [3:0] idx);
    logic [`WORD_W-1:0] value;
    if (idx == 4'd15) begin
      value = fetchIn.pcPlus8;
    end else if (writeBack.en && writeBack.dest == idx) begin
      value = writeBack.value;
    end else begin
      value = regFile[idx];
    end
    return value;
  endfunction

  always_ff @(posedge clk) begin
    if (writeBack.en && writeBack.dest != 4'd15) begin
      regFile[writeBack.dest] <= writeBack.value;
    end
  end

  always_comb begin
    decodeNext           = '0;
    decodeNext.cond      = instr[31:28];
    decodeNext.dest      = instr[15:12];
    decodeNext.opA       = readReg(instr[19:16]);
    decodeNext.opB       = readReg(instr[3:0]);
    decodeNext.storeData = readReg(instr[15:12]);
    case (instr[27:26])
      2'b00: begin
        // Rotate and shift fields of data processing are not supported
        decodeNext.useImm = instr[25];
        decodeNext.imm    = {{(`WORD_W-8){1'b0}}, instr[7:0]};
        decodeNext.regWrite = 1'b1;
        decodeNext.setFlags = instr[20];
        case (instr[24:21])
          `OP_ADD: decodeNext.aluOp = aluAdd;
          `OP_SUB: decodeNext.aluOp = aluSub;
          `OP_AND: decodeNext.aluOp = aluAnd;
          `OP_ORR: decodeNext.aluOp = aluOrr;
          default: begin
            decodeNext.regWrite = 1'b0;
            decodeNext.setFlags = 1'b0;
          end
        endcase
      end
      2'b01: begin
        // Only pre-indexed word access with an added immediate offset
        if (instr[25:21] == 5'b01100) begin
          decodeNext.aluOp  = aluAdd;
          decodeNext.useImm = 1'b1;
          decodeNext.imm    = {{(`WORD_W-12){1'b0}}, instr[11:0]};
          if (instr[20]) begin
            decodeNext.regWrite = 1'b1;
            decodeNext.memToReg = 1'b1;
          end else begin
            decodeNext.memWrite = 1'b1;
          end
        end
      end
      2'b10: begin
        // B only with the ALU adding the offset to PC+8
        if (instr[25:24] == 2'b10) begin
          decodeNext.aluOp  = aluAdd;
          decodeNext.branch = 1'b1;
          decodeNext.useImm = 1'b1;
          decodeNext.opA    = fetchIn.pcPlus8;
          decodeNext.imm    = {{(`WORD_W-26){instr[23]}}, instr[23:0], 2'b00};
        end
      end
      default: begin
        // Coprocessor space decodes to a bubble
      end
    endcase
  end

  pipeReg #(.payloadT(decodeExecT)) decodeExecReg (
    .clk   (clk),
    .rstN  (rstN),
    .flush (flush),
    .d     (decodeNext),
    .q     (decodeOut)
  );

endmodule

// ==== design/execute.sv ====
`timescale 1ns/1ps
`include "arm_consts.svh"

module execute (
  input  logic               clk,
  input  logic               rstN,
  input  armPkg::decodeExecT execIn,
  output logic               branchTaken,
  output logic [`WORD_W-1:0] branchTarget,
  output armPkg::execMemT    execOut
);
  import armPkg::*;

  logic [3:0]         flags;
  logic [3:0]         nextFlags;
  logic               flagN, flagZ, flagC, flagV;
  logic               condPass;
  logic [`WORD_W-1:0] srcB;
  logic [`WORD_W-1:0] aluResult;
  logic               carryOut;
  logic               overflow;
  execMemT            execNext;

  assign {flagN, flagZ, flagC, flagV} = flags;

  always_comb begin
    case (execIn.cond)
      `COND_EQ: condPass = flagZ;
      `COND_NE: condPass = !flagZ;
      `COND_CS: condPass = flagC;
      `COND_CC: condPass = !flagC;
      `COND_MI: condPass = flagN;
      `COND_PL: condPass = !flagN;
      `COND_VS: condPass = flagV;
      `COND_VC: condPass = !flagV;
      `COND_HI: condPass = flagC && !flagZ;
      `COND_LS: condPass = !flagC || flagZ;
      `COND_GE: condPass = (flagN == flagV);
      `COND_LT: condPass = (flagN != flagV);
      `COND_GT: condPass = !flagZ && (flagN == flagV);
      `COND_LE: condPass = flagZ || (flagN != flagV);
      `COND_AL: condPass = 1'b1;
      default:  condPass = 1'b0;
    endcase
  end

  assign srcB = execIn.useImm ? execIn.imm : execIn.opB;

  // Logic ops keep C and V since there is no shifter
  always_comb begin
    carryOut  = flagC;
    overflow  = flagV;
    aluResult = '0;
    case (execIn.aluOp)
      aluAdd: begin
        {carryOut, aluResult} = {1'b0, execIn.opA} + {1'b0, srcB};
        overflow = (execIn.opA[`WORD_W-1] == srcB[`WORD_W-1]) &&
                   (aluResult[`WORD_W-1] != execIn.opA[`WORD_W-1]);
      end
      aluSub: begin
        // Carry set means no borrow
        {carryOut, aluResult} = {1'b0, execIn.opA} + {1'b0, ~srcB} + 1'b1;
        overflow = (execIn.opA[`WORD_W-1] != srcB[`WORD_W-1]) &&
                   (aluResult[`WORD_W-1] != execIn.opA[`WORD_W-1]);
      end
      aluAnd: aluResult = execIn.opA & srcB;
      aluOrr: aluResult = execIn.opA | srcB;
      default: aluResult = '0;
    endcase
  end

  assign nextFlags = {aluResult[`WORD_W-1], aluResult == '0, carryOut, overflow};

  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
    end else if (execIn.setFlags && condPass) begin
      flags <= nextFlags;
    end
  end

  assign branchTaken  = execIn.branch && condPass;
  assign branchTarget = aluResult;

  // Failed condition leaves a bubble behind
  assign execNext.regWrite  = execIn.regWrite && condPass;
  assign execNext.memWrite  = execIn.memWrite && condPass;
  assign execNext.memToReg  = execIn.memToReg && condPass;
  assign execNext.dest      = execIn.dest;
  assign execNext.aluResult = aluResult;
  assign execNext.storeData = execIn.storeData;

  pipeReg #(.payloadT(execMemT)) execMemReg (
    .clk   (clk),
    .rstN  (rstN),
    .flush (1'b0),
    .d     (execNext),
    .q     (execOut)
  );

endmodule

// ==== design/fetch.sv ====
`timescale 1ns/1ps
`include "arm_consts.svh"

module fetch (
  input  logic                clk,
  input  logic                rstN,
  input  logic                branchTaken,
  input  logic [`WORD_W-1:0]  branchTarget,
  output logic [`WORD_W-1:0]  pc,
  input  logic [`WORD_W-1:0]  instruction,
  output armPkg::fetchDecodeT fetchOut
);
  import armPkg::*;

  fetchDecodeT fetchNext;

  // Program counter, redirected by a taken branch from execute
  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= '0;
    end else if (branchTaken) begin
      pc <= branchTarget;
    end else begin
      pc <= pc + `WORD_W'(4);
    end
  end

  // R15 reads see the fetch address plus 8
  assign fetchNext.instr   = instruction;
  assign fetchNext.pcPlus8 = pc + `WORD_W'(8);

  pipeReg #(.payloadT(fetchDecodeT)) fetchDecodeReg (
    .clk   (clk),
    .rstN  (rstN),
    .flush (branchTaken),
    .d     (fetchNext),
    .q     (fetchOut)
  );

endmodule

// ==== design/memWriteback.sv ====
`timescale 1ns/1ps
`include "arm_consts.svh"

module memWriteback (
  input  logic               clk,
  input  logic               rstN,
  input  armPkg::execMemT    memIn,
  output logic [`WORD_W-1:0] dataAddr,
  output logic [`WORD_W-1:0] writeData,
  output logic               memWrite,
  input  logic [`WORD_W-1:0] readData,
  output armPkg::regWriteT   writeBack
);
  import armPkg::*;

  memWbT memNext;
  memWbT wbStage;

  // Data memory port straight from the execute result
  assign dataAddr  = memIn.aluResult;
  assign writeData = memIn.storeData;
  assign memWrite  = memIn.memWrite;

  assign memNext.regWrite  = memIn.regWrite;
  assign memNext.memToReg  = memIn.memToReg;
  assign memNext.dest      = memIn.dest;
  assign memNext.aluResult = memIn.aluResult;
  assign memNext.readData  = readData;

  pipeReg #(.payloadT(memWbT)) memWbReg (
    .clk   (clk),
    .rstN  (rstN),
    .flush (1'b0),
    .d     (memNext),
    .q     (wbStage)
  );

  // Result mux for the register file
  assign writeBack.en    = wbStage.regWrite;
  assign writeBack.dest  = wbStage.dest;
  assign writeBack.value = wbStage.memToReg ? wbStage.readData : wbStage.aluResult;

endmodule

// ==== design/pipeReg.sv ====
`timescale 1ns/1ps

module pipeReg #(
  parameter type payloadT = logic
) (
  input  logic    clk,
  input  logic    rstN,
  input  logic    flush,
  input  payloadT d,
  output payloadT q
);

  // Zero record is a bubble for every stage type
  always_ff @(posedge clk) begin
    if (!rstN || flush) begin
      q <= '0;
    end else begin
      q <= d;
    end
  end

endmodule

// ==== tb.f ====
+incdir+design
design/armPkg.sv
design/pipeReg.sv
design/fetch.sv
design/decode.sv
design/execute.sv
design/memWriteback.sv
design/arm.sv
bench/arm_checker.sv
bench/armMonitor.sv
bench/armTb.sv
